//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vbranch_unit_tb: compile.f $(wildcard design/* verification/*)
	verilator --binary --timing --assert -f compile.f --top-module branch_unit_tb

run: obj_dir/Vbranch_unit_tb
	./obj_dir/Vbranch_unit_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module branch_unit

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+design
+incdir+verification
design/bus_pkg.sv
design/branch_pkg.sv
design/branch_ctrl.sv
design/cmp_queue.sv
design/branch_cmp.sv
design/branch_queue.sv
design/ras.sv
design/branch_unit.sv
verification/branch_unit_tb.sv

//--- design/branch_cmp.sv
`timescale 1ns/1ns
`default_nettype none

module branch_cmp (
	input branch_pkg::cmp_kind_t kind,
	input bus_pkg::operand_t opd_a,
	input bus_pkg::operand_t opd_b,
	output logic taken
);
	import branch_pkg::*;

	logic [30:0] mag_a;
	logic [30:0] mag_b;
	logic both_zero;
	logic fle;

	assign mag_a = {opd_a.fp.exponent, opd_a.fp.mantissa};
	assign mag_b = {opd_b.fp.exponent, opd_b.fp.mantissa};
	assign both_zero = mag_a == '0 && mag_b == '0;  // +0 equals -0

	// sign-magnitude order, nan not handled
	always_comb begin
		if (both_zero) begin
			fle = 1'b1;
		end else if (opd_a.fp.sign != opd_b.fp.sign) begin
			fle = opd_a.fp.sign;  // negative side is smaller
		end else if (opd_a.fp.sign) begin
			fle = mag_a >= mag_b;  // both negative
		end else begin
			fle = mag_a <= mag_b;
		end
	end

	always_comb begin
		case (kind)
			cmp_eq: taken = opd_a.word == opd_b.word;
			cmp_le: taken = $signed(opd_a.word) <= $signed(opd_b.word);
			cmp_fle: taken = fle;
			default: taken = opd_a.fp.exponent == 8'd0;  // zero or denormal
		endcase
	end

endmodule

`default_nettype wire

//--- design/branch_config.svh
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// branches in flight, also the issue credits after reset
`define BR_ENTRIES 4

// return address stack holds 2**RAS_DEPTH_LOG2 words
`define RAS_DEPTH_LOG2 3

`define TAG_WIDTH 5      // producer tag
`define ADDR_WIDTH 14    // instruction address
`define PATTERN_WIDTH 4  // branch history pattern

// count from 0 to BR_ENTRIES inclusive
`define BR_CNT_WIDTH ($clog2(`BR_ENTRIES + 1))

// slot number inside one of the queues
`define BR_IDX_WIDTH ($clog2(`BR_ENTRIES))

`endif

//--- design/branch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_config.svh"

module branch_ctrl (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic commit,
	input logic failure,
	output logic head_resolved,
	output logic [`BR_CNT_WIDTH-1:0] br_count,
	input logic [`BR_CNT_WIDTH-1:0] cmp_count,
	output logic flush,
	output logic [`BR_CNT_WIDTH-1:0] credit_return
);
	localparam int CW = `BR_CNT_WIDTH;

	logic [CW-1:0] br_count_next;

	// branches beyond the compare queue are already resolved,
	// so a gap between the two counts means the head is done
	assign head_resolved = br_count != cmp_count;

	assign flush = commit && failure;  // mispredicted head leaves

	always_comb begin
		if (flush) begin
			br_count_next = '0;  // younger ones and a same-cycle issue die too
		end else begin
			br_count_next = br_count - CW'(commit) + CW'(issue);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			br_count <= '0;
			credit_return <= '0;
		end else begin
			br_count <= br_count_next;
			if (flush) begin
				// head plus every flushed entry, the dropped issue included
				credit_return <= br_count + CW'(issue);
			end else begin
				credit_return <= CW'(commit);
			end
		end
	end

	// the issuer only spends credits it holds
	issue_has_credit: assert property (
		@(posedge clk) disable iff (reset)
		issue |-> br_count != CW'(`BR_ENTRIES)
	);

	commit_after_resolve: assert property (
		@(posedge clk) disable iff (reset)
		commit |-> head_resolved
	);

	// every waiting compare belongs to a live branch
	cmp_within_branches: assert property (
		@(posedge clk) disable iff (reset)
		cmp_count <= br_count
	);

endmodule

`default_nettype wire

//--- design/branch_pkg.sv
`default_nettype none

`include "branch_config.svh"

package branch_pkg;

	// encoding follows the opcode bits of the core
	typedef enum logic [1:0] {
		cmp_feqz = 2'd0,  // float exponent field zero
		cmp_fle  = 2'd1,  // float less-or-equal
		cmp_eq   = 2'd2,  // integer equal
		cmp_le   = 2'd3   // signed integer less-or-equal
	} cmp_kind_t;

	// points at the slot holding the current return address
	typedef logic [`RAS_DEPTH_LOG2-1:0] ras_ptr_t;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`PATTERN_WIDTH-1:0] pattern_t;

endpackage

`default_nettype wire

//--- design/branch_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_config.svh"

module branch_queue (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic commit,
	input logic flush,
	input logic [`BR_CNT_WIDTH-1:0] br_count,
	input logic prediction,
	input branch_pkg::pattern_t pattern,
	input branch_pkg::addr_t fail_addr,
	input branch_pkg::ras_ptr_t sp_snap,
	input branch_pkg::addr_t word_snap,
	input logic result_valid,
	input logic [`BR_IDX_WIDTH-1:0] result_index,
	input logic taken,
	output logic failure,
	output branch_pkg::pattern_t pattern_out,
	output branch_pkg::addr_t fail_addr_out,
	output branch_pkg::ras_ptr_t repair_sp,
	output branch_pkg::addr_t repair_word
);
	import branch_pkg::*;

	localparam int N = `BR_ENTRIES;
	localparam int CW = `BR_CNT_WIDTH;
	localparam int IW = `BR_IDX_WIDTH;

	logic q_fail [N];  // prediction until compared, then failure
	pattern_t q_pattern [N];
	addr_t q_addr [N];
	ras_ptr_t q_sp [N];
	addr_t q_word [N];

	logic [CW-1:0] wr_pos;
	logic [IW-1:0] result_slot;
	logic flip [N];

	assign wr_pos = br_count - CW'(commit);
	assign result_slot = result_index - IW'(commit);  // head may leave this cycle

	assign failure = q_fail[0];
	assign pattern_out = q_pattern[0];
	assign fail_addr_out = q_addr[0];
	assign repair_sp = q_sp[0];
	assign repair_word = q_word[0];

	for (genvar i = 0; i < N; i++) begin : g_slot
		localparam int NEXT = (i < N - 1) ? i + 1 : i;

		assign flip[i] = result_valid && !flush && taken && result_slot == IW'(i);

		always_ff @(posedge clk) begin
			if (reset) begin
				q_fail[i] <= 1'b0;
			end else if (issue && !flush && wr_pos == CW'(i)) begin
				q_fail[i] <= prediction;
				q_pattern[i] <= pattern;
				q_addr[i] <= fail_addr;
				q_sp[i] <= sp_snap;
				q_word[i] <= word_snap;
			end else if (commit) begin
				q_fail[i] <= q_fail[NEXT] ^ flip[i];
				q_pattern[i] <= q_pattern[NEXT];
				q_addr[i] <= q_addr[NEXT];
				q_sp[i] <= q_sp[NEXT];
				q_word[i] <= q_word[NEXT];
			end else begin
				q_fail[i] <= q_fail[i] ^ flip[i];
			end
		end
	end

	// a result always lands on a branch that is still here
	result_in_range: assert property (
		@(posedge clk) disable iff (reset)
		result_valid |-> CW'(result_index) < br_count
	);

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_config.svh"

module branch_unit (
	input logic clk,
	input logic reset,
	input logic issue,
	input branch_pkg::cmp_kind_t cmp_kind,
	input logic rd_valid [2],
	input bus_pkg::tag_t rd_tag [2],
	input bus_pkg::operand_t rd_data [2],
	input logic imm_valid,
	input bus_pkg::operand_t imm,
	input logic prediction,
	input branch_pkg::pattern_t pattern,
	input branch_pkg::addr_t fail_addr,
	output logic [`BR_CNT_WIDTH-1:0] credit_return,
	input logic cdb_valid,
	input bus_pkg::tag_t cdb_tag,
	input bus_pkg::operand_t cdb_data,
	input logic commit,
	output logic head_resolved,
	output logic failure,
	output branch_pkg::pattern_t pattern_out,
	output branch_pkg::addr_t fail_addr_out,
	input logic call,
	input logic ret,
	input branch_pkg::addr_t pc,
	output branch_pkg::addr_t return_addr
);
	import bus_pkg::*;
	import branch_pkg::*;

	logic [`BR_CNT_WIDTH-1:0] br_count;
	logic [`BR_CNT_WIDTH-1:0] cmp_count;
	logic flush;
	logic dispatch;
	logic [`BR_IDX_WIDTH-1:0] dispatch_index;
	cmp_kind_t head_kind;
	operand_t head_opd [2];
	logic taken;
	ras_ptr_t sp_snap;
	addr_t word_snap;
	ras_ptr_t repair_sp;
	addr_t repair_word;

	branch_ctrl u_ctrl (
		.clk(clk), .reset(reset), .issue(issue), .commit(commit), .failure(failure),
		.head_resolved(head_resolved), .br_count(br_count), .cmp_count(cmp_count),
		.flush(flush), .credit_return(credit_return)
	);

	cmp_queue u_cmp_queue (
		.clk(clk), .reset(reset), .issue(issue), .flush(flush), .cmp_kind(cmp_kind),
		.rd_valid(rd_valid), .rd_tag(rd_tag), .rd_data(rd_data),
		.imm_valid(imm_valid), .imm(imm),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.br_count(br_count), .dispatch(dispatch), .head_kind(head_kind),
		.head_opd(head_opd), .cmp_count(cmp_count), .dispatch_index(dispatch_index)
	);

	branch_cmp u_cmp (
		.kind(head_kind), .opd_a(head_opd[0]), .opd_b(head_opd[1]), .taken(taken)
	);

	branch_queue u_branch_queue (
		.clk(clk), .reset(reset), .issue(issue), .commit(commit), .flush(flush),
		.br_count(br_count), .prediction(prediction), .pattern(pattern),
		.fail_addr(fail_addr), .sp_snap(sp_snap), .word_snap(word_snap),
		.result_valid(dispatch), .result_index(dispatch_index), .taken(taken),
		.failure(failure), .pattern_out(pattern_out), .fail_addr_out(fail_addr_out),
		.repair_sp(repair_sp), .repair_word(repair_word)
	);

	// a failed commit rolls the stack back to the head's snapshot
	ras u_ras (
		.clk(clk), .reset(reset), .call(call), .ret(ret), .pc(pc),
		.repair(flush), .repair_sp(repair_sp), .repair_word(repair_word),
		.sp_snap(sp_snap), .word_snap(word_snap), .return_addr(return_addr)
	);

endmodule

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

`include "branch_config.svh"

package bus_pkg;

	// producer tag on the read ports and the cdb
	typedef logic [`TAG_WIDTH-1:0] tag_t;

	// one operand word as it travels on the read ports and the cdb.
	// integer compares read it as a signed word, float compares
	// read the ieee single fields
	typedef union packed {
		logic signed [31:0] word;
		struct packed {
			logic sign;
			logic [7:0] exponent;
			logic [22:0] mantissa;
		} fp;
	} operand_t;

endpackage

`default_nettype wire

//--- design/cmp_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_config.svh"

module cmp_queue (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic flush,
	input branch_pkg::cmp_kind_t cmp_kind,
	input logic rd_valid [2],
	input bus_pkg::tag_t rd_tag [2],
	input bus_pkg::operand_t rd_data [2],
	input logic imm_valid,
	input bus_pkg::operand_t imm,
	input logic cdb_valid,
	input bus_pkg::tag_t cdb_tag,
	input bus_pkg::operand_t cdb_data,
	input logic [`BR_CNT_WIDTH-1:0] br_count,
	output logic dispatch,
	output branch_pkg::cmp_kind_t head_kind,
	output bus_pkg::operand_t head_opd [2],
	output logic [`BR_CNT_WIDTH-1:0] cmp_count,
	output logic [`BR_IDX_WIDTH-1:0] dispatch_index
);
	import bus_pkg::*;
	import branch_pkg::*;

	localparam int N = `BR_ENTRIES;
	localparam int CW = `BR_CNT_WIDTH;

	cmp_kind_t q_kind [N];
	logic q_valid [N][2];
	tag_t q_tag [N][2];
	operand_t q_data [N][2];

	// entries after this cycle's cdb capture
	logic upd_valid [N][2];
	operand_t upd_data [N][2];

	logic new_valid [2];
	operand_t new_data [2];

	logic [CW-1:0] wr_pos;
	logic [CW-1:0] resolved_count;

	always_comb begin
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < 2; j++) begin
				upd_valid[i][j] = q_valid[i][j] || (cdb_valid && q_tag[i][j] == cdb_tag);
				upd_data[i][j] = q_valid[i][j] ? q_data[i][j] : cdb_data;
			end
		end
	end

	// incoming entry, may catch the cdb in its own issue cycle
	always_comb begin
		for (int j = 0; j < 2; j++) begin
			new_valid[j] = rd_valid[j] || (cdb_valid && rd_tag[j] == cdb_tag);
			new_data[j] = rd_valid[j] ? rd_data[j] : cdb_data;
		end
		if (imm_valid) begin
			new_valid[1] = 1'b1;  // immediate replaces operand 1
			new_data[1] = imm;
		end
	end

	// only the head leaves, is-zero needs no second operand
	assign dispatch = cmp_count != '0 && q_valid[0][0]
		&& (q_valid[0][1] || q_kind[0] == cmp_feqz);

	assign head_kind = q_kind[0];
	assign head_opd[0] = q_data[0][0];
	assign head_opd[1] = q_data[0][1];

	// resolved branches sit in front of the head in the branch queue
	assign resolved_count = br_count - cmp_count;
	assign dispatch_index = resolved_count[`BR_IDX_WIDTH-1:0];

	assign wr_pos = cmp_count - CW'(dispatch);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			cmp_count <= '0;
		end else begin
			cmp_count <= wr_pos + CW'(issue);
		end
	end

	for (genvar i = 0; i < N; i++) begin : g_slot
		localparam int NEXT = (i < N - 1) ? i + 1 : i;

		always_ff @(posedge clk) begin
			if (issue && wr_pos == CW'(i)) begin
				q_kind[i] <= cmp_kind;
				for (int j = 0; j < 2; j++) begin
					q_valid[i][j] <= new_valid[j];
					q_tag[i][j] <= rd_tag[j];
					q_data[i][j] <= new_data[j];
				end
			end else if (dispatch) begin
				q_kind[i] <= q_kind[NEXT];  // shift toward head
				for (int j = 0; j < 2; j++) begin
					q_valid[i][j] <= upd_valid[NEXT][j];
					q_tag[i][j] <= q_tag[NEXT][j];
					q_data[i][j] <= upd_data[NEXT][j];
				end
			end else begin
				for (int j = 0; j < 2; j++) begin
					q_valid[i][j] <= upd_valid[i][j];
					q_data[i][j] <= upd_data[i][j];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/ras.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_config.svh"

module ras (
	input logic clk,
	input logic reset,
	input logic call,
	input logic ret,
	input branch_pkg::addr_t pc,
	input logic repair,
	input branch_pkg::ras_ptr_t repair_sp,
	input branch_pkg::addr_t repair_word,
	output branch_pkg::ras_ptr_t sp_snap,
	output branch_pkg::addr_t word_snap,
	output branch_pkg::addr_t return_addr
);
	import branch_pkg::*;

	localparam int DEPTH = 2 ** `RAS_DEPTH_LOG2;

	addr_t stack [DEPTH];
	ras_ptr_t sp;  // slot of the current return address
	ras_ptr_t sp_next;
	ras_ptr_t wr_ptr;
	addr_t wr_data;
	logic wr_en;
	addr_t top_next;

	assign sp_snap = sp;
	assign word_snap = stack[sp + 1'b1];  // the word a later call overwrites

	always_comb begin
		sp_next = sp;
		wr_en = 1'b0;
		wr_ptr = sp + 1'b1;
		wr_data = pc;
		if (repair) begin
			sp_next = repair_sp;
			wr_en = 1'b1;
			wr_ptr = repair_sp + 1'b1;
			wr_data = repair_word;
		end else if (call) begin
			sp_next = sp + 1'b1;
			wr_en = 1'b1;
		end else if (ret) begin
			sp_next = sp - 1'b1;
		end
	end

	// bypass a write into the new top
	assign top_next = (wr_en && wr_ptr == sp_next) ? wr_data : stack[sp_next];

	always_ff @(posedge clk) begin
		if (reset) begin
			sp <= '1;  // top slot
		end else begin
			sp <= sp_next;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			stack[wr_ptr] <= wr_data;
		end
		return_addr <= top_next;
	end

endmodule

`default_nettype wire

//--- verification/branch_tests.svh
// expected failure is prediction xor condition
task automatic int_compares();
	logic [31:0] a;
	logic [31:0] b;
	cur_test = "int_compares";
	run_compare(cmp_eq, 32'd17, 32'd17, 1'b1, 1'b1);
	run_compare(cmp_eq, 32'd17, 32'd18, 1'b1, 1'b0);
	run_compare(cmp_eq, 32'd5, 32'd5, 1'b0, 1'b1);
	run_compare(cmp_le, 32'hFFFF_FFF0, 32'd3, 1'b0, 1'b1);  // -16 <= 3
	run_compare(cmp_le, 32'd3, 32'hFFFF_FFF0, 1'b1, 1'b0);
	run_compare(cmp_le, 32'd9, 32'd9, 1'b1, 1'b1);
	// read port 1 never becomes valid here
	issue_branch(cmp_eq, 1'b1, '0, 32'd99, 1'b0, 5'd3, 32'd99, 1'b1, 1'b0);
	commit_head(1'b1);
	repeat (4) begin
		a = $random(seed);
		b = $random(seed);
		// negative side is smaller, same signs order as unsigned words
		run_compare(cmp_le, a, b, a[0], (a[31] != b[31]) ? a[31] : (a <= b));
	end
endtask

task automatic cdb_wakeup();
	cur_test = "cdb_wakeup";
	issue_branch(cmp_eq, 1'b0, 5'd5, 32'd0, 1'b1, '0, 32'd42, 1'b0, 1'b0);
	repeat (3) begin
		tick();
		expect_eq("resolved before cdb", 0, 32'(head_resolved));
	end
	broadcast(5'd6, 32'd7);  // other producer
	tick();
	expect_eq("resolved on other tag", 0, 32'(head_resolved));
	broadcast(5'd5, 32'd42);
	commit_head(1'b1);
	// cdb hit in the issue cycle itself, stale port data of -16 would flip it
	cdb_valid = 1'b1;
	cdb_tag = 5'd9;
	cdb_data = 32'd10;
	issue_branch(cmp_le, 1'b1, '0, 32'hFFFF_FFFD, 1'b0, 5'd9, 32'hFFFF_FFF0, 1'b0, 1'b1);
	cdb_valid = 1'b0;
	expect_eq("resolved at issue", 0, 32'(head_resolved));
	tick();
	expect_eq("resolved one cycle later", 1, 32'(head_resolved));
	commit_head(1'b0);  // -3 <= 10
endtask

task automatic float_compares();
	cur_test = "float_compares";
	run_compare(cmp_fle, 32'hC000_0000, 32'hBF80_0000, 1'b0, 1'b1);  // -2.0 <= -1.0
	run_compare(cmp_fle, 32'hBF80_0000, 32'hC000_0000, 1'b0, 1'b0);
	run_compare(cmp_fle, 32'h3F80_0000, 32'h4000_0000, 1'b1, 1'b1);
	run_compare(cmp_fle, 32'h4000_0000, 32'h3F80_0000, 1'b1, 1'b0);
	run_compare(cmp_fle, 32'hBF80_0000, 32'h3F80_0000, 1'b0, 1'b1);
	run_compare(cmp_fle, 32'h3F80_0000, 32'hBF80_0000, 1'b0, 1'b0);
	run_compare(cmp_fle, 32'h0000_0000, 32'h8000_0000, 1'b0, 1'b1);  // +0 vs -0
	run_compare(cmp_fle, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b1);
	run_compare(cmp_feqz, 32'h0000_0001, 32'd0, 1'b0, 1'b1);  // denormal
	run_compare(cmp_feqz, 32'h3F80_0000, 32'd0, 1'b0, 1'b0);
	run_compare(cmp_feqz, 32'h8000_0000, 32'd0, 1'b1, 1'b1);
	// is-zero goes without its second operand
	issue_branch(cmp_feqz, 1'b1, '0, 32'h0040_0000, 1'b0, 5'd12, 32'd0, 1'b0, 1'b0);
	commit_head(1'b1);
endtask

task automatic credit_flow();
	cur_test = "credit_flow";
	expect_eq("credits before fill", `BR_ENTRIES, credits);
	issue_branch(cmp_eq, 1'b1, '0, 32'd1, 1'b1, '0, 32'd1, 1'b0, 1'b1);
	issue_branch(cmp_eq, 1'b1, '0, 32'd1, 1'b1, '0, 32'd2, 1'b0, 1'b1);  // mispredicted
	issue_branch(cmp_le, 1'b1, '0, 32'd1, 1'b1, '0, 32'd2, 1'b0, 1'b1);
	issue_branch(cmp_le, 1'b1, '0, 32'd2, 1'b1, '0, 32'd1, 1'b0, 1'b0);
	expect_eq("credits when full", 0, credits);
	repeat (4) tick();
	expect_eq("credits while holding", 0, credits);
	commit_head(1'b0);
	expect_eq("credits after commit", 1, credits);
	commit_head(1'b1);
	expect_eq("credits after flush", `BR_ENTRIES, credits);
	expect_eq("resolved after flush", 0, 32'(head_resolved));
endtask

task automatic return_stack();
	cur_test = "return_stack";
	push_call(14'h111);
	expect_eq("top after call", 32'h111, 32'(return_addr));
	push_call(14'h222);
	push_call(14'h333);
	expect_eq("top after third call", 32'h333, 32'(return_addr));
	pop_return();
	expect_eq("top after return", 32'h222, 32'(return_addr));
	pop_return();
	expect_eq("top after second return", 32'h111, 32'(return_addr));
	// wrong-path call behind a mispredicted branch
	issue_branch(cmp_eq, 1'b1, '0, 32'd1, 1'b1, '0, 32'd1, 1'b0, 1'b0);
	push_call(14'h444);
	expect_eq("top after wrong-path call", 32'h444, 32'(return_addr));
	commit_head(1'b1);
	expect_eq("top after repair", 32'h111, 32'(return_addr));
	push_call(14'h555);
	expect_eq("top after later call", 32'h555, 32'(return_addr));
	pop_return();
	expect_eq("top after later return", 32'h111, 32'(return_addr));
endtask

//--- verification/branch_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_config.svh"

module branch_unit_tb;
	import bus_pkg::*;
	import branch_pkg::*;

	localparam int CYCLE_LIMIT = 600;  // all tests plus margin

	logic clk;
	logic reset;
	logic issue;
	cmp_kind_t cmp_kind;
	logic rd_valid [2];
	tag_t rd_tag [2];
	operand_t rd_data [2];
	logic imm_valid;
	operand_t imm;
	logic prediction;
	pattern_t pattern;
	addr_t fail_addr;
	logic [`BR_CNT_WIDTH-1:0] credit_return;
	logic cdb_valid;
	tag_t cdb_tag;
	operand_t cdb_data;
	logic commit;
	logic head_resolved;
	logic failure;
	pattern_t pattern_out;
	addr_t fail_addr_out;
	logic call;
	logic ret;
	addr_t pc;
	addr_t return_addr;

	int credits;  // as the issuer sees them
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int issue_seq = 0;
	integer seed = 32'h9397_bce6;
	string cur_test = "reset";
	pattern_t exp_pattern [$];  // branches in flight, oldest first
	addr_t exp_addr [$];

	branch_unit i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic tick();
		@(negedge clk);
		credits = credits + int'(credit_return);
	endtask

	task automatic expect_eq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task report_and_finish();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			errors = errors + 1;
			$display("timeout, run stopped after %0d cycles", cycles);
			report_and_finish();
		end
	end

	task automatic clear_inputs();
		issue = 1'b0;
		cmp_kind = cmp_eq;
		for (int j = 0; j < 2; j++) begin
			rd_valid[j] = 1'b0;
			rd_tag[j] = '0;
			rd_data[j] = '0;
		end
		imm_valid = 1'b0;
		imm = '0;
		prediction = 1'b0;
		pattern = '0;
		fail_addr = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit = 1'b0;
		call = 1'b0;
		ret = 1'b0;
		pc = '0;
	endtask

	// with use_imm set, d1 goes out as the immediate and port 1 carries junk
	task automatic issue_branch(input cmp_kind_t kind, input logic v0, input tag_t t0,
			input logic [31:0] d0, input logic v1, input tag_t t1, input logic [31:0] d1,
			input logic use_imm, input logic pred);
		if (credits == 0) begin
			errors++;
			$display("%s: issue attempted with no credit left", cur_test);
		end else begin
			issue = 1'b1;
			cmp_kind = kind;
			rd_valid[0] = v0;
			rd_tag[0] = t0;
			rd_data[0] = d0;
			rd_valid[1] = v1;
			rd_tag[1] = t1;
			rd_data[1] = use_imm ? ~d1 : d1;
			imm_valid = use_imm;
			imm = d1;
			prediction = pred;
			pattern = pattern_t'(issue_seq);
			fail_addr = addr_t'(32'h200 + issue_seq);
			exp_pattern.push_back(pattern);
			exp_addr.push_back(fail_addr);
			credits--;
			issue_seq++;
			tick();
			issue = 1'b0;
			imm_valid = 1'b0;
		end
	endtask

	task automatic broadcast(input tag_t tag, input logic [31:0] data);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_data = data;
		tick();
		cdb_valid = 1'b0;
	endtask

	task automatic wait_resolved();
		int n;
		n = 0;
		while (!head_resolved && n < 20) begin
			tick();
			n++;
		end
		if (!head_resolved) begin
			errors++;
			$display("%s: head branch never resolved", cur_test);
		end
	endtask

	task automatic commit_head(input logic exp_fail);
		int exp_credit;
		wait_resolved();
		expect_eq("failure", 32'(exp_fail), 32'(failure));
		if (exp_pattern.size() == 0) begin
			errors++;
			$display("%s: commit with no branch in flight", cur_test);
		end else if (head_resolved) begin
			expect_eq("pattern_out", 32'(exp_pattern[0]), 32'(pattern_out));
			expect_eq("fail_addr_out", 32'(exp_addr[0]), 32'(fail_addr_out));
			exp_credit = exp_fail ? exp_pattern.size() : 1;  // head plus the flushed
			commit = 1'b1;
			tick();
			commit = 1'b0;
			expect_eq("credit_return", exp_credit, 32'(credit_return));
			if (exp_fail) begin
				exp_pattern.delete();
				exp_addr.delete();
			end else begin
				exp_pattern.delete(0);
				exp_addr.delete(0);
			end
		end
	endtask

	// unit must be empty, so the new branch is the head
	task automatic run_compare(input cmp_kind_t kind, input logic [31:0] a,
			input logic [31:0] b, input logic pred, input logic exp_taken);
		issue_branch(kind, 1'b1, '0, a, 1'b1, '0, b, 1'b0, pred);
		expect_eq("resolved at issue", 0, 32'(head_resolved));
		tick();
		expect_eq("resolved one cycle later", 1, 32'(head_resolved));
		commit_head(pred ^ exp_taken);
	endtask

	task automatic push_call(input addr_t addr);
		call = 1'b1;
		pc = addr;
		tick();
		call = 1'b0;
	endtask

	task automatic pop_return();
		ret = 1'b1;
		tick();
		ret = 1'b0;
	endtask

	`include "branch_tests.svh"

	initial begin
		clear_inputs();
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		credits = `BR_ENTRIES;
		expect_eq("head_resolved", 0, 32'(head_resolved));
		expect_eq("credit_return", 0, 32'(credit_return));
		expect_eq("failure", 0, 32'(failure));
		int_compares();
		cdb_wakeup();
		float_compares();
		credit_flow();
		return_stack();
		report_and_finish();
	end

endmodule

`default_nettype wire
